//--- dac_mixer.sv
// dac output mixer of the dsp hub
// per channel masking of the direct outputs
// pipelined adder tree, pairs then quads then total, final sum register
// clamp to the 14 bit dac range with overflow flags

`timescale 1ns/1ps

module dac_mixer
   import dsp_pkg::*;
(
   input  logic                             clk_i,
   input  logic                             rstn_i,
   input  logic [NUM_DIRECT-1:0][DAT_W-1:0] direct_i,   // slots 0..3, asg1, asg2
   input  out_sel_e [NUM_DIRECT-1:0]        out_sel_i,
   output logic [DAT_W-1:0]                 dat_a_o,
   output logic [DAT_W-1:0]                 dat_b_o,
   output logic [1:0]                       sat_o       // bit 0 dac a, bit 1 dac b
);

   logic signed [SUM_W-1:0] leaf_a  [2][TREE_LEAVES];    // masked, sign extended
   logic signed [SUM_W-1:0] node_q  [2][TREE_LEAVES-1];  // heap of tree nodes
   logic signed [SUM_W-1:0] sum_q   [2];
   logic        [DAT_W-1:0] clamp_a [2];

   // leaves, channel c takes output k when out_sel bit c is set
   always_comb begin
      for (int c = 0; c < 2; c++) begin
         for (int k = 0; k < TREE_LEAVES; k++) begin
            leaf_a[c][k] = '0;  // padding leaves stay zero
         end
         for (int k = 0; k < NUM_DIRECT; k++) begin
            if (out_sel_i[k][c]) begin
               leaf_a[c][k] = {{SEL_W{direct_i[k][DAT_W-1]}}, direct_i[k]};
            end
         end
      end
   end

   // adder tree
   // nodes 0..3 pairs, 4..5 quads, 6 total, one level per clock
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int c = 0; c < 2; c++) begin
            for (int n = 0; n < TREE_LEAVES-1; n++) begin
               node_q[c][n] <= '0;
            end
            sum_q[c] <= '0;   // dacs idle at zero after reset
         end
      end else begin
         for (int c = 0; c < 2; c++) begin
            for (int n = 0; n < TREE_LEAVES/2; n++) begin
               node_q[c][n] <= leaf_a[c][2*n] + leaf_a[c][2*n+1];
            end
            // level l starts at TREE_LEAVES - (TREE_LEAVES >> l)
            for (int l = 1; l < MIX_LAT-1; l++) begin
               for (int n = 0; n < (TREE_LEAVES >> (l+1)); n++) begin
                  node_q[c][TREE_LEAVES - (TREE_LEAVES >> l) + n] <=
                     node_q[c][TREE_LEAVES - (TREE_LEAVES >> (l-1)) + 2*n] +
                     node_q[c][TREE_LEAVES - (TREE_LEAVES >> (l-1)) + 2*n + 1];
               end
            end
            sum_q[c] <= node_q[c][TREE_LEAVES-2];  // root, extra stage for slack
         end
      end
   end

   // saturation
   always_comb begin
      for (int c = 0; c < 2; c++) begin
         // in range when every bit above the dac sign matches the sum sign
         sat_o[c] = (sum_q[c][SUM_W-1:DAT_W-1] != {(SEL_W+1){sum_q[c][SUM_W-1]}});
         if (!sat_o[c]) begin
            clamp_a[c] = sum_q[c][DAT_W-1:0];
         end else if (sum_q[c][SUM_W-1]) begin
            clamp_a[c] = {1'b1, {(DAT_W-1){1'b0}}};  // -8192
         end else begin
            clamp_a[c] = {1'b0, {(DAT_W-1){1'b1}}};  // +8191
         end
      end
   end

   assign dat_a_o = clamp_a[0];
   assign dat_b_o = clamp_a[1];

endmodule

//--- dsp_ctrl.sv
// register bus front end of the dsp hub
// source/output select registers with reset routing, sync register
// registered readback mux and one cycle ack

`timescale 1ns/1ps

module dsp_ctrl
   import dsp_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       rstn_i,
   input  logic [31:0]                sys_addr_i,
   input  logic [31:0]                sys_wdata_i,
   input  logic                       sys_wen_i,
   input  logic                       sys_ren_i,
   output logic [31:0]                sys_rdata_o,
   output logic                       sys_ack_o,
   input  logic [1:0]                 sat_i,        // dac b, dac a overflow
   input  logic [DAT_W-1:0]           rd_signal_i,  // source picked by rd_idx_o
   output src_e     [NUM_SINKS-1:0]   in_sel_o,
   output out_sel_e [NUM_DIRECT-1:0]  out_sel_o,
   output logic [NUM_SLOTS-1:0]       sync_o,
   output logic [SEL_W-1:0]           rd_idx_o
);

   logic [SLOT_LSB-1:0]       offset;   // register offset within the hub
   logic [SEL_W-1:0]          idx;      // slot/sink index field
   logic                      in_ok;    // index names a real sink
   logic                      out_ok;   // index names a real direct output
   src_e     [NUM_SINKS-1:0]  in_sel_q;
   out_sel_e [NUM_DIRECT-1:0] out_sel_q;
   logic [NUM_SLOTS-1:0]      sync_q;
   logic [31:0]               rdata_d;

   assign offset = sys_addr_i[SLOT_LSB-1:0];
   assign idx    = sys_addr_i[SLOT_LSB +: SEL_W];
   assign in_ok  = (idx < NUM_SINKS);
   assign out_ok = (idx < NUM_DIRECT);

   // configuration registers
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         // slots and scope 1 look at adc a by default
         for (int k = 0; k < NUM_SINKS; k++) begin
            in_sel_q[k] <= SRC_ADC1;
         end
         in_sel_q[SINK_SCOPE2] <= SRC_ADC2;
         in_sel_q[SINK_PWM0]   <= SRC_NONE;  // pwm quiet until routed
         in_sel_q[SINK_PWM1]   <= SRC_NONE;
         for (int k = 0; k < NUM_DIRECT; k++) begin
            out_sel_q[k] <= OUT_OFF;         // nothing reaches the dacs
         end
         sync_q <= '1;                       // all slots running
      end else if (sys_wen_i) begin
         case (offset)
            REG_INSEL: begin
               if (in_ok) begin
                  in_sel_q[idx[$clog2(NUM_SINKS)-1:0]] <= src_e'(sys_wdata_i[SEL_W-1:0]);
               end
            end
            REG_OUTSEL: begin
               if (out_ok) begin
                  out_sel_q[idx[$clog2(NUM_DIRECT)-1:0]] <= out_sel_e'(sys_wdata_i[1:0]);
               end
            end
            REG_SYNC: sync_q <= sys_wdata_i[NUM_SLOTS-1:0];
            default: ;  // read only or unmapped
         endcase
      end
   end

   // readback source, registered below
   always_comb begin
      rdata_d = '0;
      case (offset)
         REG_INSEL: begin
            if (in_ok) begin
               rdata_d = {{(32-SEL_W){1'b0}}, in_sel_q[idx[$clog2(NUM_SINKS)-1:0]]};
            end
         end
         REG_OUTSEL: begin
            if (out_ok) begin
               rdata_d = {{(32-$bits(out_sel_e)){1'b0}},
                          out_sel_q[idx[$clog2(NUM_DIRECT)-1:0]]};
            end
         end
         REG_SAT:    rdata_d = {30'd0, sat_i};  // flags of this cycle
         REG_SYNC:   rdata_d = {{(32-NUM_SLOTS){1'b0}}, sync_q};
         REG_SIGNAL: rdata_d = {{(32-DAT_W){1'b0}}, rd_signal_i};
         default:    rdata_d = '0;              // unknown offsets read zero
      endcase
   end

   // every request is acked one cycle later, no stall
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         sys_ack_o <= 1'b0;
      end else begin
         sys_ack_o <= sys_wen_i | sys_ren_i;
      end
   end

   always_ff @(posedge clk_i) begin
      sys_rdata_o <= rdata_d;  // only looked at together with ack
   end

   assign in_sel_o  = in_sel_q;
   assign out_sel_o = out_sel_q;
   assign sync_o    = sync_q;
   assign rd_idx_o  = idx;     // router serves REG_SIGNAL reads

endmodule

//--- dsp_hub.f
dsp_pkg.sv
dsp_ctrl.sv
signal_router.sv
dac_mixer.sv
dsp_hub.sv
tb_dsp_hub.sv

//--- dsp_hub.sv
// top level of the dsp routing hub
// bus control, source crossbar and dac mixer
// slot, scope and pwm sinks split out of the router

`timescale 1ns/1ps

module dsp_hub
   import dsp_pkg::*;
(
   input  logic                            clk_i,
   input  logic                            rstn_i,
   input  logic [DAT_W-1:0]                adc_a_i,
   input  logic [DAT_W-1:0]                adc_b_i,
   input  logic [DAT_W-1:0]                asg1_i,
   input  logic [DAT_W-1:0]                asg2_i,
   input  logic [NUM_SLOTS-1:0][DAT_W-1:0] slot_dat_i,  // slot results
   input  logic [31:0]                     sys_addr_i,
   input  logic [31:0]                     sys_wdata_i,
   input  logic                            sys_wen_i,
   input  logic                            sys_ren_i,
   output logic [NUM_SLOTS-1:0][DAT_W-1:0] slot_dat_o,  // routed slot inputs
   output logic [DAT_W-1:0]                scope1_o,
   output logic [DAT_W-1:0]                scope2_o,
   output logic [DAT_W-1:0]                pwm0_o,
   output logic [DAT_W-1:0]                pwm1_o,
   output logic [DAT_W-1:0]                dat_a_o,
   output logic [DAT_W-1:0]                dat_b_o,
   output logic [NUM_SLOTS-1:0]            sync_o,
   output logic [31:0]                     sys_rdata_o,
   output logic                            sys_ack_o
);

   src_e     [NUM_SINKS-1:0]          in_sel;
   out_sel_e [NUM_DIRECT-1:0]         out_sel;
   logic     [SEL_W-1:0]              rd_idx;
   logic     [DAT_W-1:0]              rd_signal;
   logic     [1:0]                    sat;
   logic     [NUM_SINKS-1:0][DAT_W-1:0] sink_dat;

   dsp_ctrl dsp_ctrl_inst (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .sys_addr_i  (sys_addr_i),
      .sys_wdata_i (sys_wdata_i),
      .sys_wen_i   (sys_wen_i),
      .sys_ren_i   (sys_ren_i),
      .sys_rdata_o (sys_rdata_o),
      .sys_ack_o   (sys_ack_o),
      .sat_i       (sat),
      .rd_signal_i (rd_signal),
      .in_sel_o    (in_sel),
      .out_sel_o   (out_sel),
      .sync_o      (sync_o),
      .rd_idx_o    (rd_idx)
   );

   signal_router signal_router_inst (
      .slot_dat_i  (slot_dat_i),
      .asg1_i      (asg1_i),
      .asg2_i      (asg2_i),
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .dac_a_i     (dat_a_o),    // dac feedback into the crossbar
      .dac_b_i     (dat_b_o),
      .in_sel_i    (in_sel),
      .rd_idx_i    (rd_idx),
      .sink_dat_o  (sink_dat),
      .rd_signal_o (rd_signal)
   );

   dac_mixer dac_mixer_inst (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .direct_i  ({asg2_i, asg1_i, slot_dat_i}),  // asg2 is the top contributor
      .out_sel_i (out_sel),
      .dat_a_o   (dat_a_o),
      .dat_b_o   (dat_b_o),
      .sat_o     (sat)
   );

   // sink split
   assign slot_dat_o = sink_dat[SINK_SLOT3:SINK_SLOT0];
   assign scope1_o   = sink_dat[SINK_SCOPE1];
   assign scope2_o   = sink_dat[SINK_SCOPE2];
   assign pwm0_o     = sink_dat[SINK_PWM0];
   assign pwm1_o     = sink_dat[SINK_PWM1];

endmodule

//--- dsp_pkg.sv
// shared constants for the dsp routing hub
// source and sink codes, dac output select, register offsets

package dsp_pkg;

   localparam int DAT_W       = 14;             // adc/dac sample width
   localparam int SEL_W       = 4;              // source select width
   localparam int SUM_W       = DAT_W + SEL_W;  // headroom for the adder tree
   localparam int NUM_SLOTS   = 4;              // external processing slots
   localparam int NUM_SINKS   = 8;
   localparam int NUM_DIRECT  = 6;              // slots 0..3, asg1, asg2
   localparam int TREE_LEAVES = 8;              // direct inputs padded to 2**n
   localparam int MIX_LAT     = 4;              // three tree levels plus sum reg
   localparam int SLOT_LSB    = 16;             // slot index sits above the offset

   // routing sources, codes 10..14 select zero like SRC_NONE
   typedef enum logic [SEL_W-1:0] {
      SRC_SLOT0 = 4'd0,
      SRC_SLOT1 = 4'd1,
      SRC_SLOT2 = 4'd2,
      SRC_SLOT3 = 4'd3,
      SRC_ASG1  = 4'd4,
      SRC_ASG2  = 4'd5,
      SRC_ADC1  = 4'd6,
      SRC_ADC2  = 4'd7,
      SRC_DAC1  = 4'd8,   // dac feedback
      SRC_DAC2  = 4'd9,   // highest real source
      SRC_NONE  = 4'd15
   } src_e;

   // routed sinks
   typedef enum logic [2:0] {
      SINK_SLOT0, SINK_SLOT1, SINK_SLOT2, SINK_SLOT3,
      SINK_SCOPE1, SINK_SCOPE2,
      SINK_PWM0, SINK_PWM1
   } sink_e;

   // bit 0 feeds dac a, bit 1 feeds dac b
   typedef enum logic [1:0] {OUT_OFF, OUT_1, OUT_2, OUT_BOTH} out_sel_e;

   typedef enum logic [15:0] {
      REG_INSEL  = 16'h0000,  // per sink source select
      REG_OUTSEL = 16'h0004,  // per direct output dac select
      REG_SAT    = 16'h0008,  // dac overflow flags, read only
      REG_SYNC   = 16'h000C,
      REG_SIGNAL = 16'h0010   // live source value, read only
   } reg_off_e;

endpackage

//--- run_sim.sh
#!/bin/sh
# build and run the dsp hub testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_dsp_hub -f dsp_hub.f -o sim_dsp_hub
out=$(./obj_dir/sim_dsp_hub)
echo "$out"
if echo "$out" | grep -q "SIMULATION PASSED"; then
   exit 0
else
   exit 1
fi

//--- signal_router.sv
// combinational crossbar of the dsp hub
// ten entry source table, one select mux per sink
// extra mux for bus readback of a source value

`timescale 1ns/1ps

module signal_router
   import dsp_pkg::*;
(
   input  logic [NUM_SLOTS-1:0][DAT_W-1:0] slot_dat_i,  // slot outputs
   input  logic [DAT_W-1:0]                asg1_i,
   input  logic [DAT_W-1:0]                asg2_i,
   input  logic [DAT_W-1:0]                adc_a_i,
   input  logic [DAT_W-1:0]                adc_b_i,
   input  logic [DAT_W-1:0]                dac_a_i,     // mixer output fed back
   input  logic [DAT_W-1:0]                dac_b_i,
   input  src_e [NUM_SINKS-1:0]            in_sel_i,
   input  logic [SEL_W-1:0]                rd_idx_i,
   output logic [NUM_SINKS-1:0][DAT_W-1:0] sink_dat_o,
   output logic [DAT_W-1:0]                rd_signal_o
);

   logic [DAT_W-1:0] src_tab [0:SRC_DAC2];  // indexed by source code

   // source table
   always_comb begin
      for (int k = 0; k < NUM_SLOTS; k++) begin
         src_tab[SRC_SLOT0 + k] = slot_dat_i[k];
      end
      src_tab[SRC_ASG1] = asg1_i;
      src_tab[SRC_ASG2] = asg2_i;
      src_tab[SRC_ADC1] = adc_a_i;
      src_tab[SRC_ADC2] = adc_b_i;
      src_tab[SRC_DAC1] = dac_a_i;
      src_tab[SRC_DAC2] = dac_b_i;
   end

   // sink muxes, anything past dac2 gives zero
   always_comb begin
      for (int k = 0; k < NUM_SINKS; k++) begin
         if (in_sel_i[k] <= SRC_DAC2) begin
            sink_dat_o[k] = src_tab[in_sel_i[k]];
         end else begin
            sink_dat_o[k] = '0;  // SRC_NONE and the spare codes
         end
      end
   end

   // bus view of a single source
   always_comb begin
      if (rd_idx_i <= SRC_DAC2) begin
         rd_signal_o = src_tab[rd_idx_i];
      end else begin
         rd_signal_o = '0;
      end
   end

endmodule

//--- tb_dsp_hub.sv
// testbench for the dsp routing hub
// random bus and sample stimulus from an lcg, reference model of registers,
// crossbar and the four stage dac mixer, checks with error count

`timescale 1ns/1ps

module tb_dsp_hub
   import dsp_pkg::*;
();

   logic clk_i, rstn_i;
   logic [DAT_W-1:0] adc_a_i, adc_b_i, asg1_i, asg2_i;
   logic [NUM_SLOTS-1:0][DAT_W-1:0] slot_dat_i, slot_dat_o;
   logic [31:0] sys_addr_i, sys_wdata_i, sys_rdata_o;
   logic sys_wen_i, sys_ren_i, sys_ack_o;
   logic [DAT_W-1:0] scope1_o, scope2_o, pwm0_o, pwm1_o, dat_a_o, dat_b_o;
   logic [NUM_SLOTS-1:0] sync_o;

   int unsigned seed = 94;
   int errors = 0;
   int cycles = 0;
   logic [DAT_W-1:0] src_m [10];        // model source table with the dacs at 8 and 9
   logic [3:0] in_sel_m [NUM_SINKS];
   logic [1:0] out_sel_m [NUM_DIRECT];
   logic [3:0] sync_m;
   logic [1:0] sat_m;

   dsp_hub dsp_hub_inst (.*);

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   // cycle limit for the whole run
   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= 3000) begin
         $display("timeout, the tests did not finish within 3000 cycles");
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   function logic [31:0] lcg();
      seed = seed * 32'd1103515245 + 32'd12345;
      return {17'd0, seed[30:16]};     // upper bits spread better
   endfunction

   function logic [31:0] reg_addr(int idx, reg_off_e off);
      return {12'd0, 4'(idx), 16'(off)};
   endfunction

   task check(string name, logic [31:0] exp, logic [31:0] act);
      if (exp !== act) begin
         errors++;
         $display("Fail t=%0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   // register write rules with out of range indices ignored
   function void model_write(logic [31:0] a, logic [31:0] d);
      case (a[15:0])
         REG_INSEL:  if (a[19:16] < NUM_SINKS) in_sel_m[a[18:16]] = d[3:0];
         REG_OUTSEL: if (a[19:16] < NUM_DIRECT) out_sel_m[a[18:16]] = d[1:0];
         REG_SYNC:   sync_m = d[3:0];
         default: ;
      endcase
   endfunction

   function logic [31:0] model_read(logic [31:0] a);
      case (a[15:0])
         REG_INSEL:  return (a[19:16] < NUM_SINKS) ? {28'd0, in_sel_m[a[18:16]]} : 32'd0;
         REG_OUTSEL: return (a[19:16] < NUM_DIRECT) ? {30'd0, out_sel_m[a[18:16]]} : 32'd0;
         REG_SAT:    return {30'd0, sat_m};
         REG_SYNC:   return {28'd0, sync_m};
         REG_SIGNAL: return (a[19:16] < 10) ? {18'd0, src_m[a[19:16]]} : 32'd0;
         default:    return 32'd0;
      endcase
   endfunction

   function logic [DAT_W-1:0] route(logic [3:0] code);
      return (code < 10) ? src_m[code] : '0;  // none and spare codes
   endfunction

   // unsaturated channel sum where direct k is source k
   function int mix_sum(int c);
      int s;
      s = 0;
      for (int k = 0; k < NUM_DIRECT; k++) begin
         if (out_sel_m[k][c]) s = s + $signed(src_m[k]);
      end
      return s;
   endfunction

   function logic [DAT_W-1:0] clamp14(int s);
      if (s > 8191) return 14'h1fff;
      if (s < -8192) return 14'h2000;
      return s[DAT_W-1:0];
   endfunction

   function logic ovf(int s);
      return (s > 8191) || (s < -8192);
   endfunction

   task wait_ack();
      int n;
      n = 0;
      @(negedge clk_i);
      while (!sys_ack_o && n < 4) begin
         n++;
         @(negedge clk_i);
      end
      if (!sys_ack_o) begin
         errors++;
         $display("bus request at t=%0t got no ack", $time);
      end else if (n != 0) begin
         errors++;
         $display("bus ack at t=%0t came %0d cycles late", $time, n);
      end
   endtask

   task bus_write(logic [31:0] a, logic [31:0] d);
      @(posedge clk_i);
      sys_addr_i  <= a;
      sys_wdata_i <= d;
      sys_wen_i   <= 1'b1;
      @(posedge clk_i);
      sys_wen_i <= 1'b0;
      wait_ack();
      model_write(a, d);  // committed at the ack edge
   endtask

   task read_check(logic [31:0] a);
      @(posedge clk_i);
      sys_addr_i <= a;
      sys_ren_i  <= 1'b1;
      @(posedge clk_i);
      sys_ren_i <= 1'b0;
      wait_ack();
      check($sformatf("sys_rdata_o @%h", a), model_read(a), sys_rdata_o);
   endtask

   // call right after a rising edge
   task drive_sources(logic rnd, logic [DAT_W-1:0] v);
      logic [31:0] r;
      for (int k = 0; k < 8; k++) begin
         r = lcg();
         src_m[k] = rnd ? r[DAT_W-1:0] : v;
      end
      slot_dat_i <= {src_m[3], src_m[2], src_m[1], src_m[0]};
      asg1_i  <= src_m[4];
      asg2_i  <= src_m[5];
      adc_a_i <= rnd ? src_m[6] : adc_a_i;
      adc_b_i <= rnd ? src_m[7] : adc_b_i;
      if (!rnd) begin
         src_m[6] = adc_a_i;  // adcs keep their value
         src_m[7] = adc_b_i;
      end
   endtask

   task check_sinks();
      for (int k = 0; k < NUM_SLOTS; k++) begin
         check($sformatf("slot_dat_o[%0d]", k), route(in_sel_m[k]), slot_dat_o[k]);
      end
      check("scope1_o", route(in_sel_m[SINK_SCOPE1]), scope1_o);
      check("scope2_o", route(in_sel_m[SINK_SCOPE2]), scope2_o);
      check("pwm0_o", route(in_sel_m[SINK_PWM0]), pwm0_o);
      check("pwm1_o", route(in_sel_m[SINK_PWM1]), pwm1_o);
   endtask

   // wait for constant inputs to fill the mixer pipeline
   task check_mixer_steady();
      repeat (MIX_LAT + 1) @(negedge clk_i);
      src_m[8] = clamp14(mix_sum(0));
      src_m[9] = clamp14(mix_sum(1));
      sat_m = {ovf(mix_sum(1)), ovf(mix_sum(0))};
      check("dat_a_o", src_m[8], dat_a_o);
      check("dat_b_o", src_m[9], dat_b_o);
      read_check(reg_addr(0, REG_SAT));
   endtask

   initial begin
      logic [31:0] a, d, r;
      int hist_a [$];
      int hist_b [$];
      rstn_i = 1'b0;
      sys_addr_i = '0;
      sys_wdata_i = '0;
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
      adc_a_i = '0;
      adc_b_i = '0;
      asg1_i = '0;
      asg2_i = '0;
      slot_dat_i = '0;
      for (int k = 0; k < 10; k++) src_m[k] = '0;
      for (int k = 0; k < NUM_SINKS; k++) in_sel_m[k] = SRC_ADC1;
      in_sel_m[SINK_SCOPE2] = SRC_ADC2;
      in_sel_m[SINK_PWM0] = SRC_NONE;
      in_sel_m[SINK_PWM1] = SRC_NONE;
      for (int k = 0; k < NUM_DIRECT; k++) out_sel_m[k] = OUT_OFF;
      sync_m = 4'hf;
      sat_m = 2'b00;
      repeat (5) @(posedge clk_i);
      rstn_i <= 1'b1;

      // reset defaults
      @(negedge clk_i);
      check("sys_ack_o", 0, sys_ack_o);
      check("pwm0_o", 0, pwm0_o);
      check("pwm1_o", 0, pwm1_o);
      check("dat_a_o", 0, dat_a_o);
      check("dat_b_o", 0, dat_b_o);
      for (int k = 0; k < NUM_SINKS; k++) read_check(reg_addr(k, REG_INSEL));
      for (int k = 0; k < NUM_DIRECT; k++) read_check(reg_addr(k, REG_OUTSEL));
      read_check(reg_addr(0, REG_SYNC));

      // routing with the dacs still at zero
      for (int i = 0; i < 60; i++) begin
         a = lcg();
         d = lcg();
         bus_write(reg_addr(a % NUM_SINKS, REG_INSEL), d % 16);
         @(posedge clk_i);
         drive_sources(1'b1, '0);
         @(negedge clk_i);
         check_sinks();
      end

      // mixing with one bus write and one new sample each cycle
      for (int i = 0; i < 200; i++) begin
         @(posedge clk_i);
         drive_sources(1'b1, '0);
         r = lcg();
         a = reg_addr(r % 8, REG_OUTSEL);  // 6 and 7 are ignored
         d = lcg();
         sys_addr_i  <= a;
         sys_wdata_i <= d;
         sys_wen_i   <= 1'b1;
         @(negedge clk_i);
         hist_a.push_back(mix_sum(0));  // selects from before this write
         hist_b.push_back(mix_sum(1));
         model_write(a, d);
         if (hist_a.size() > MIX_LAT) begin
            src_m[8] = clamp14(hist_a.pop_front());
            src_m[9] = clamp14(hist_b.pop_front());
            check("dat_a_o", src_m[8], dat_a_o);
            check("dat_b_o", src_m[9], dat_b_o);
            check_sinks();  // dac feedback through the crossbar
         end
      end
      @(posedge clk_i);
      sys_wen_i <= 1'b0;

      // saturation both ways and then all off
      for (int k = 0; k < NUM_DIRECT; k++) bus_write(reg_addr(k, REG_OUTSEL), OUT_BOTH);
      @(posedge clk_i);
      drive_sources(1'b0, 14'h1fff);  // +8191 on all six
      check_mixer_steady();
      check("REG_SAT", 3, sys_rdata_o);
      @(posedge clk_i);
      drive_sources(1'b0, 14'h2000);  // -8192 on all six
      check_mixer_steady();
      for (int k = 0; k < NUM_DIRECT; k++) bus_write(reg_addr(k, REG_OUTSEL), OUT_OFF);
      check_mixer_steady();
      check("REG_SAT", 0, sys_rdata_o);

      // sync and signal readback plus out of range and unknown offsets
      for (int i = 0; i < 8; i++) begin
         d = lcg();
         bus_write(reg_addr(0, REG_SYNC), d);
         check("sync_o", sync_m, sync_o);
         read_check(reg_addr(0, REG_SYNC));
      end
      for (int k = 0; k < 16; k++) read_check(reg_addr(k, REG_SIGNAL));
      for (int k = NUM_SINKS; k < 16; k++) begin
         bus_write(reg_addr(k, REG_INSEL), lcg());
         read_check(reg_addr(k, REG_INSEL));
      end
      for (int k = NUM_DIRECT; k < 16; k++) begin
         bus_write(reg_addr(k, REG_OUTSEL), lcg());
         read_check(reg_addr(k, REG_OUTSEL));
      end
      for (int k = 0; k < NUM_SINKS; k++) read_check(reg_addr(k, REG_INSEL));
      bus_write(32'h0000_0014, 32'hffff_ffff);
      read_check(32'h0000_0014);
      read_check(32'h0003_0100);
      read_check(32'h0000_fffc);

      $display("run done after %0d cycles, %0d errors", cycles, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule
